// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = fp_pipe_tb
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== compile.f ====
rtl/fp_format_pkg.sv
rtl/fpu_ctrl_pkg.sv
rtl/rv32f_reg_file.sv
rtl/fp_operand_stage.sv
rtl/fp_sign_minmax_unit.sv
rtl/fp_pipe_top.sv
test/fp_pipe_checker.sv
test/fp_pipe_tb.sv

// ==== rtl/fp_format_pkg.sv ====
// single-precision format package
// field layout, canonical quiet NaN and the NaN classifiers
// used by the execute unit and the testbench reference model
package fp_format_pkg;

  localparam int SIGN_BIT = 31;
  localparam int EXP_W    = 8;
  localparam int MAN_W    = 23;

  typedef logic [31:0] fp_word_t; // raw IEEE 754 binary32 pattern

  // quiet NaN, positive, only the top mantissa bit set
  localparam fp_word_t qnan_canonical = 32'h7fc0_0000;

  // exponent all ones and a nonzero mantissa
  function automatic logic is_nan(input fp_word_t w);
    logic [EXP_W-1:0] exp_f;
    logic [MAN_W-1:0] man_f;
    exp_f = w[SIGN_BIT-1 -: EXP_W];
    man_f = w[MAN_W-1:0];
    return (&exp_f) && (|man_f);
  endfunction

  // signalling when the quiet bit (mantissa msb) is clear
  function automatic logic is_snan(input fp_word_t w);
    logic quiet_bit;
    quiet_bit = w[MAN_W-1];
    return is_nan(w) && !quiet_bit;
  endfunction

  // sign bit, kept as a helper so callers never hardcode 31
  function automatic logic sign_of(input fp_word_t w);
    return w[SIGN_BIT];
  endfunction

endpackage

// ==== rtl/fp_operand_stage.sv ====
// operand read stage
// picks each source from execute forward, writeback or the
// register file, then registers the instruction into execute
`timescale 1ns/1ps

module fp_operand_stage
  import fp_format_pkg::*;
  import fpu_ctrl_pkg::*;
#(
  parameter int NUM_REGS = 32,
  localparam int IDX_W = $clog2(NUM_REGS)
) (
  input  logic             frf_rf,
  input  logic             rst,
  input  logic             instr_valid,
  input  fpu_op_t          op,
  input  logic [IDX_W-1:0] rd,
  input  logic [IDX_W-1:0] rs1,
  input  logic [IDX_W-1:0] rs2,
  input  fp_word_t         int_data,
  input  fp_word_t         rs1_data,
  input  fp_word_t         rs2_data,
  input  logic             fwd_valid,
  input  logic [IDX_W-1:0] fwd_rd,
  input  fp_word_t         fwd_data,
  input  logic             wb_valid,
  input  logic [IDX_W-1:0] wb_rd,
  input  fp_word_t         wb_data,
  output logic             ex_valid,
  output fpu_op_t          ex_op,
  output logic [IDX_W-1:0] ex_rd,
  output fp_word_t         ex_a,
  output fp_word_t         ex_b
);

  fp_word_t src1, src2;

  // youngest producer wins: execute, then writeback, then the array
  function automatic fp_word_t pick_src(input logic [IDX_W-1:0] idx,
                                        input fp_word_t rf_val);
    fp_word_t val;
    val = rf_val;
    if (wb_valid && wb_rd == idx) val = wb_data;
    if (fwd_valid && fwd_rd == idx) val = fwd_data;
    return val;
  endfunction

  assign src1 = pick_src(rs1, rs1_data);
  assign src2 = pick_src(rs2, rs2_data);

  always_ff @(posedge frf_rf) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= instr_valid; // no stall, every slot moves
    end
  end

  // payload, no reset needed
  always_ff @(posedge frf_rf) begin
    ex_op <= op;
    ex_rd <= rd;
    ex_a  <= (op == op_mv_w_x) ? int_data : src1; // fmv.w.x takes x-reg bits
    ex_b  <= src2;
  end

endmodule

// ==== rtl/fp_pipe_top.sv ====
// RV32F sign / min-max pipeline top level
// operand read, execute and writeback around the float register file
// one instruction per cycle, no stall, results 2 cycles after issue
`timescale 1ns/1ps

module fp_pipe_top
  import fp_format_pkg::*;
  import fpu_ctrl_pkg::*;
#(
  parameter int NUM_REGS = 32,
  localparam int IDX_W = $clog2(NUM_REGS)
) (
  input  logic             frf_rf,
  input  logic             rst,
  input  logic             instr_valid,
  input  fpu_op_t          op,
  input  logic [IDX_W-1:0] rd,
  input  logic [IDX_W-1:0] rs1,
  input  logic [IDX_W-1:0] rs2,
  input  fp_word_t         int_data,
  input  frm_t             frm_in,
  output logic             wb_valid,
  output logic [IDX_W-1:0] wb_rd,
  output fp_word_t         wb_data,
  output fflags_t          fflags,
  output frm_t             frm
);

  // read port results
  fp_word_t rs1_data, rs2_data;

  // operand stage to execute
  logic             ex_valid;
  fpu_op_t          ex_op;
  logic [IDX_W-1:0] ex_rd;
  fp_word_t         ex_a, ex_b;

  // execute forward path
  logic             fwd_valid;
  logic [IDX_W-1:0] fwd_rd;
  fp_word_t         fwd_data;

  fflags_t wb_flags; // only the register file sees these directly

  fp_operand_stage #(.NUM_REGS(NUM_REGS)) opnd_i (
    .frf_rf, .rst, .instr_valid, .op, .rd, .rs1, .rs2, .int_data,
    .rs1_data, .rs2_data,
    .fwd_valid, .fwd_rd, .fwd_data,
    .wb_valid, .wb_rd, .wb_data,
    .ex_valid, .ex_op, .ex_rd, .ex_a, .ex_b
  );

  fp_sign_minmax_unit #(.NUM_REGS(NUM_REGS)) exec_i (
    .frf_rf, .rst, .ex_valid, .ex_op, .ex_rd, .ex_a, .ex_b,
    .fwd_valid, .fwd_rd, .fwd_data,
    .wb_valid, .wb_rd, .wb_data, .wb_flags
  );

  rv32f_reg_file #(.NUM_REGS(NUM_REGS)) rf_i (
    .frf_rf, .rst, .wb_valid, .wb_rd, .wb_data, .wb_flags, .frm_in,
    .rs1, .rs2, .rs1_data, .rs2_data, .frm, .fflags
  );

endmodule

// ==== rtl/fp_sign_minmax_unit.sv ====
// execute stage for the ops that need no rounding
// sign injection, fmin/fmax with RISC-V NaN rules and fmv.w.x
// result is forwarded combinationally and registered for writeback
`timescale 1ns/1ps

module fp_sign_minmax_unit
  import fp_format_pkg::*;
  import fpu_ctrl_pkg::*;
#(
  parameter int NUM_REGS = 32,
  localparam int IDX_W = $clog2(NUM_REGS)
) (
  input  logic             frf_rf,
  input  logic             rst,
  input  logic             ex_valid,
  input  fpu_op_t          ex_op,
  input  logic [IDX_W-1:0] ex_rd,
  input  fp_word_t         ex_a,
  input  fp_word_t         ex_b,
  output logic             fwd_valid,
  output logic [IDX_W-1:0] fwd_rd,
  output fp_word_t         fwd_data,
  output logic             wb_valid,
  output logic [IDX_W-1:0] wb_rd,
  output fp_word_t         wb_data,
  output fflags_t          wb_flags
);

  logic     sign_a, sign_b;
  logic     nan_a, nan_b;
  logic     a_lt_b;      // a below b as signed magnitudes
  fp_word_t mag_a;       // a with sign cleared
  fp_word_t min_val, max_val;
  fp_word_t result;
  fflags_t  flags;

  assign sign_a = sign_of(ex_a);
  assign sign_b = sign_of(ex_b);
  assign nan_a  = is_nan(ex_a);
  assign nan_b  = is_nan(ex_b);
  assign mag_a  = {1'b0, ex_a[30:0]};

  // ordering, -0 sits below +0 through the sign compare
  always_comb begin
    if (sign_a != sign_b) begin
      a_lt_b = sign_a; // negative side is smaller
    end else if (!sign_a) begin
      a_lt_b = ex_a[30:0] < ex_b[30:0];
    end else begin
      a_lt_b = ex_a[30:0] > ex_b[30:0]; // both negative, bigger mag is smaller
    end
  end

  // one NaN returns the other operand, two give canonical
  always_comb begin
    if (nan_a && nan_b) begin
      min_val = qnan_canonical;
      max_val = qnan_canonical;
    end else if (nan_a) begin
      min_val = ex_b;
      max_val = ex_b;
    end else if (nan_b) begin
      min_val = ex_a;
      max_val = ex_a;
    end else begin
      min_val = a_lt_b ? ex_a : ex_b;
      max_val = a_lt_b ? ex_b : ex_a;
    end
  end

  always_comb begin
    flags = FLAGS_NONE;
    unique case (ex_op)
      op_sgnj:   result = mag_a | {sign_b, 31'b0};
      op_sgnjn:  result = mag_a | {~sign_b, 31'b0};
      op_sgnjx:  result = mag_a | {sign_a ^ sign_b, 31'b0};
      op_min:    result = min_val;
      op_max:    result = max_val;
      op_mv_w_x: result = ex_a; // raw bits, no canonicalising
      default:   result = ex_a;
    endcase
    if ((ex_op == op_min || ex_op == op_max) && (is_snan(ex_a) || is_snan(ex_b))) begin
      flags[FLAG_NV] = 1'b1; // only an sNaN raises invalid
    end
  end

  // forward to the operand stage in the same cycle
  assign fwd_valid = ex_valid;
  assign fwd_rd    = ex_rd;
  assign fwd_data  = result;

  always_ff @(posedge frf_rf) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= ex_valid;
    end
  end

  always_ff @(posedge frf_rf) begin
    wb_rd    <= ex_rd;
    wb_data  <= result;
    wb_flags <= flags;
  end

endmodule

// ==== rtl/fpu_ctrl_pkg.sv ====
// FPU control package
// operation encoding for the non-rounding ops, exception flag
// positions as in fcsr and the rounding mode type
package fpu_ctrl_pkg;

  localparam int OP_W  = 3;
  localparam int FRM_W = 3;
  localparam int FLAGS_W = 5;

  typedef enum logic [OP_W-1:0] {
    op_sgnj   = 3'd0, // fsgnj.s
    op_sgnjn  = 3'd1, // fsgnjn.s
    op_sgnjx  = 3'd2, // fsgnjx.s
    op_min    = 3'd3, // fmin.s
    op_max    = 3'd4, // fmax.s
    op_mv_w_x = 3'd5  // fmv.w.x, int bits into a float reg
  } fpu_op_t;

  // fflags order matches fcsr[4:0]
  localparam int FLAG_NV = 4; // invalid
  localparam int FLAG_DZ = 3; // divide by zero
  localparam int FLAG_OF = 2; // overflow
  localparam int FLAG_UF = 1; // underflow
  localparam int FLAG_NX = 0; // inexact

  typedef logic [FLAGS_W-1:0] fflags_t;
  typedef logic [FRM_W-1:0]   frm_t;

  localparam fflags_t FLAGS_NONE = '0;

endpackage

// ==== rtl/rv32f_reg_file.sv ====
// rv32f float register file
// NUM_REGS x 32-bit registers plus the frm / fflags part of fcsr
// two combinational read ports, one write port from writeback
`timescale 1ns/1ps

module rv32f_reg_file
  import fp_format_pkg::*;
  import fpu_ctrl_pkg::*;
#(
  parameter int NUM_REGS = 32,
  localparam int IDX_W = $clog2(NUM_REGS)
) (
  input  logic             frf_rf,
  input  logic             rst,
  input  logic             wb_valid,
  input  logic [IDX_W-1:0] wb_rd,
  input  fp_word_t         wb_data,
  input  fflags_t          wb_flags,
  input  frm_t             frm_in,
  input  logic [IDX_W-1:0] rs1,
  input  logic [IDX_W-1:0] rs2,
  output fp_word_t         rs1_data,
  output fp_word_t         rs2_data,
  output frm_t             frm,
  output fflags_t          fflags
);

  fp_word_t regs [NUM_REGS];
  frm_t     frm_q;   // fcsr[7:5]
  fflags_t  flags_q; // fcsr[4:0]

  always_ff @(posedge frf_rf) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      frm_q   <= '0;
      flags_q <= '0;
    end else begin
      frm_q <= frm_in; // tracks its input every cycle
      if (wb_valid) begin
        regs[wb_rd] <= wb_data;
        flags_q     <= wb_flags; // replaced, not accumulated
      end
    end
  end

  // reads see the old value on a same-cycle write;
  // the operand stage forwards from writeback to cover that
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  assign frm    = frm_q;
  assign fflags = flags_q;

endmodule

// ==== test/fp_pipe_checker.sv ====
// timing checks for the pipeline top level
// writeback latency, state after reset and the frm register
`timescale 1ns/1ps

module fp_pipe_checker
  import fpu_ctrl_pkg::*;
(
  input logic frf_rf,
  input logic rst,
  input logic instr_valid,
  input logic ex_valid,
  input logic wb_valid,
  input frm_t frm_in,
  input frm_t frm
);

  int unsigned fail_count = 0; // assertion failures so far

  // every issued slot reaches writeback two edges later
  property issue_to_wb;
    @(posedge frf_rf) disable iff (rst) instr_valid |-> ##2 wb_valid;
  endproperty

  property wb_from_issue; // no writeback without a matching issue
    @(posedge frf_rf) disable iff (rst) wb_valid |-> $past(instr_valid, 2);
  endproperty

  property quiet_after_reset;
    @(posedge frf_rf) $fell(rst) |-> !wb_valid && !ex_valid;
  endproperty

  // status register tracks its input with one cycle delay
  property frm_follows;
    @(posedge frf_rf) disable iff (rst) !$past(rst) |-> frm == $past(frm_in);
  endproperty

  issue_to_wb_a: assert property (issue_to_wb) else begin
    fail_count++;
    $error("issued slot never wrote back");
  end
  wb_from_issue_a: assert property (wb_from_issue) else begin
    fail_count++;
    $error("writeback without an issue");
  end
  reset_a: assert property (quiet_after_reset) else begin
    fail_count++;
    $error("pipeline busy after reset");
  end
  frm_a: assert property (frm_follows) else begin
    fail_count++;
    $error("frm lost its input");
  end

endmodule

bind fp_pipe_top fp_pipe_checker chk_i (
  .frf_rf(frf_rf),
  .rst(rst),
  .instr_valid(instr_valid),
  .ex_valid(ex_valid),
  .wb_valid(wb_valid),
  .frm_in(frm_in),
  .frm(frm)
);

// ==== test/fp_pipe_tb.sv ====
// testbench for the RV32F sign / min-max pipeline
// in-order reference model over a shadow register file,
// writeback and fflags compared by immediate assertions
`timescale 1ns/1ps

module fp_pipe_tb
  import fp_format_pkg::*;
  import fpu_ctrl_pkg::*;
();

  localparam int NUM_REGS   = 32;
  localparam int IDX_W      = $clog2(NUM_REGS);
  localparam int MAX_CYCLES = 400; // sequence needs ~310

  typedef struct packed {
    logic [IDX_W-1:0] rd;
    fp_word_t         data;
    fflags_t          flags;
  } exp_t;

  logic             frf_rf;
  logic             rst;
  logic             instr_valid;
  fpu_op_t          op;
  logic [IDX_W-1:0] rd;
  logic [IDX_W-1:0] rs1;
  logic [IDX_W-1:0] rs2;
  fp_word_t         int_data;
  frm_t             frm_in;
  logic             wb_valid;
  logic [IDX_W-1:0] wb_rd;
  fp_word_t         wb_data;
  fflags_t          fflags;
  frm_t             frm;

  fp_word_t shadow [NUM_REGS]; // architectural state, issue order
  exp_t     exp_q [$];         // results not yet written back
  logic     flag_pending;      // fflags due on the next negedge
  fflags_t  flag_exp;
  int       seed = 32'h3d05;
  int       cycles;
  int       r1, r2, r3, r4;

  fp_pipe_top #(.NUM_REGS(NUM_REGS)) dut_i (
    .frf_rf, .rst, .instr_valid, .op, .rd, .rs1, .rs2, .int_data, .frm_in,
    .wb_valid, .wb_rd, .wb_data, .fflags, .frm
  );

  initial begin
    frf_rf = 1'b0;
    forever #5 frf_rf = ~frf_rf;
  end

  function automatic logic nan_pattern(input fp_word_t w);
    return (w[30:23] == 8'hff) && (w[22:0] != 23'd0);
  endfunction

  function automatic logic signalling_nan(input fp_word_t w);
    return nan_pattern(w) && !w[22]; // quiet bit clear
  endfunction

  // monotonic key, negatives flipped so -0 lands just below +0
  function automatic logic [31:0] order_key(input fp_word_t w);
    return w[31] ? {1'b0, ~w[30:0]} : {1'b1, w[30:0]};
  endfunction

  function automatic exp_t expected_result(input fpu_op_t o, input logic [IDX_W-1:0] d,
                                           input fp_word_t a, input fp_word_t b,
                                           input fp_word_t x);
    exp_t e;
    e.rd    = d;
    e.flags = 5'b0;
    case (o)
      op_sgnj:   e.data = {b[31], a[30:0]};
      op_sgnjn:  e.data = {~b[31], a[30:0]};
      op_sgnjx:  e.data = {a[31] ^ b[31], a[30:0]};
      op_mv_w_x: e.data = x;
      default: begin // min / max
        if (nan_pattern(a) && nan_pattern(b)) e.data = 32'h7fc0_0000;
        else if (nan_pattern(a)) e.data = b;
        else if (nan_pattern(b)) e.data = a;
        else if (o == op_min) e.data = (order_key(a) < order_key(b)) ? a : b;
        else e.data = (order_key(a) > order_key(b)) ? a : b;
        e.flags[4] = signalling_nan(a) || signalling_nan(b); // NV
      end
    endcase
    return e;
  endfunction

  // first n_ops encodings, move is the last one
  function automatic fpu_op_t op_from_random(input int r, input int n_ops);
    int unsigned k;
    k = $unsigned(r) % n_ops;
    return fpu_op_t'(k[2:0]);
  endfunction

  // value per register index, every bit of the index matters
  function automatic fp_word_t move_pattern(input int i);
    return (i * 32'h0101_0101) ^ 32'hbf80_0000 ^ (i << 23);
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Regression failed");
  endtask

  // one instruction on the next edge, model updated in issue order
  task automatic issue(input fpu_op_t o, input int d, input int s1, input int s2,
                       input fp_word_t x);
    exp_t             e;
    logic [IDX_W-1:0] di, ai, bi;
    di = d[IDX_W-1:0];
    ai = s1[IDX_W-1:0];
    bi = s2[IDX_W-1:0];
    e  = expected_result(o, di, shadow[ai], shadow[bi], x);
    @(posedge frf_rf);
    instr_valid <= 1'b1;
    op          <= o;
    rd          <= di;
    rs1         <= ai;
    rs2         <= bi;
    int_data    <= x;
    exp_q.push_back(e);
    shadow[di] = e.data;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge frf_rf);
      instr_valid <= 1'b0;
    end
  endtask

  task automatic reset_midstream();
    @(posedge frf_rf);
    rst         <= 1'b1;
    instr_valid <= 1'b0;
    repeat (3) @(posedge frf_rf);
    rst <= 1'b0;
    for (int i = 0; i < NUM_REGS; i++) shadow[i] = '0;
  endtask

  // sampled mid-cycle, well away from the driving edge
  always @(negedge frf_rf) begin : wb_monitor
    exp_t e;
    if (dut_i.chk_i.fail_count != 0) begin
      report_failure("timing checker found a protocol violation");
      $fatal(1, "checker assertion failed");
    end
    if (rst) begin
      exp_q.delete(); // in-flight work is dropped by reset
      flag_pending = 1'b0;
    end else begin
      if (flag_pending) begin
        assert (fflags == flag_exp) else begin
          report_failure($sformatf("** Error @ %0t: fflags exp %b got %b",
                                   $time, flag_exp, fflags));
          $fatal(1, "fflags mismatch");
        end
        flag_pending = 1'b0;
      end
      if (wb_valid) begin
        assert (exp_q.size() != 0) else begin
          report_failure("writeback seen with no instruction outstanding");
          $fatal(1, "unexpected writeback");
        end
        e = exp_q.pop_front();
        assert (wb_rd == e.rd && wb_data == e.data) else begin
          report_failure($sformatf("** Error @ %0t: rd exp %0d got %0d, data exp %h got %h",
                                   $time, e.rd, wb_rd, e.data, wb_data));
          $fatal(1, "writeback mismatch");
        end
        flag_pending = 1'b1; // status written on the next edge
        flag_exp     = e.flags;
      end
    end
  end

  always @(posedge frf_rf) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      report_failure($sformatf("timeout, sequence not done within %0d cycles", MAX_CYCLES));
      $fatal(1, "timeout");
    end
  end

  initial begin
    rst          = 1'b1;
    instr_valid  = 1'b0;
    op           = op_sgnj;
    rd           = '0;
    rs1          = '0;
    rs2          = '0;
    int_data     = '0;
    frm_in       = '0;
    flag_pending = 1'b0;
    cycles       = 0;
    for (int i = 0; i < NUM_REGS; i++) shadow[i] = '0;
    repeat (3) @(posedge frf_rf);
    rst <= 1'b0;

    for (int i = 0; i < NUM_REGS; i++) issue(op_mv_w_x, i, 0, 0, move_pattern(i));

    // sign injection, ops in rotation
    for (int k = 0; k < 30; k++) begin
      r1 = $random(seed);
      r2 = $random(seed);
      r3 = $random(seed);
      issue((k % 3 == 0) ? op_sgnj : (k % 3 == 1) ? op_sgnjn : op_sgnjx,
            $unsigned(r1) % NUM_REGS, $unsigned(r2) % NUM_REGS, $unsigned(r3) % NUM_REGS, 0);
    end

    // min / max corners: +0 -0 qNaN sNaN 1.0 -2.0
    issue(op_mv_w_x, 1, 0, 0, 32'h0000_0000);
    issue(op_mv_w_x, 2, 0, 0, 32'h8000_0000);
    issue(op_mv_w_x, 3, 0, 0, 32'h7fc0_0001);
    issue(op_mv_w_x, 4, 0, 0, 32'h7f80_0001);
    issue(op_mv_w_x, 5, 0, 0, 32'h3f80_0000);
    issue(op_mv_w_x, 6, 0, 0, 32'hc000_0000);
    issue(op_min, 20, 1, 2, 0);
    issue(op_max, 21, 2, 1, 0);
    issue(op_min, 22, 3, 5, 0); // one quiet NaN
    issue(op_max, 23, 5, 3, 0);
    issue(op_min, 24, 3, 3, 0); // canonical NaN
    issue(op_max, 25, 3, 4, 0); // canonical plus NV
    issue(op_min, 26, 4, 5, 0);
    issue(op_min, 27, 5, 6, 0);
    issue(op_max, 28, 6, 5, 0);
    issue(op_sgnj, 29, 5, 6, 0); // NV cleared again

    // dependent chains at distance 1, 2, 3
    for (int d = 1; d <= 3; d++) begin
      for (int k = 0; k < 4; k++) begin
        r1 = $random(seed);
        r2 = $random(seed);
        issue(op_from_random(r1, 5), 12 + k, (k >= d) ? 12 + k - d : 5, 6, r2); // no move
      end
    end

    // same rd in execute and writeback, the younger one must win
    issue(op_mv_w_x, 16, 0, 0, 32'h4120_0000);
    issue(op_mv_w_x, 16, 0, 0, 32'h4040_0000);
    issue(op_sgnj, 17, 16, 16, 0);

    for (int n = 0; n < 200; n++) begin
      r1 = $random(seed);
      r2 = $random(seed);
      r3 = $random(seed);
      r4 = $random(seed);
      issue(op_from_random(r1, 6), $unsigned(r2) % NUM_REGS, $unsigned(r3) % NUM_REGS,
            $unsigned(r4) % NUM_REGS, r4 ^ r2);
      frm_in <= r3[2:0];
    end

    // reset with work in flight, then reads of cleared registers
    issue(op_mv_w_x, 7, 0, 0, 32'h4049_0fdb);
    issue(op_sgnjn, 8, 7, 7, 0);
    reset_midstream();
    issue(op_min, 7, 8, 9, 0);
    issue(op_sgnjn, 9, 3, 3, 0);
    issue(op_max, 10, 9, 2, 0);
    issue(op_sgnjx, 11, 31, 9, 0);
    idle(4); // latency is fixed at two cycles plus the status write

    if (dut_i.chk_i.fail_count != 0) begin
      report_failure("timing checker found a protocol violation");
      $fatal(1, "checker assertion failed");
    end else if (exp_q.size() != 0 || flag_pending) begin
      report_failure("results still outstanding after the pipeline drained");
      $fatal(1, "missing writeback");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule
